// ==== common/router_pkg.sv ====
`default_nettype none

package router_pkg;

    localparam int num_ports = 5;

    // port numbering, also the bit order of every port mask
    localparam int port_local = 0;
    localparam int port_east  = 1;
    localparam int port_north = 2;
    localparam int port_west  = 3;
    localparam int port_south = 4;

    localparam int coord_w   = 3;   // one mesh coordinate
    localparam int payload_w = 32;

    typedef logic [2:0] port_idx_t;
    typedef logic [num_ports-1:0] port_mask_t;

    typedef enum logic [1:0] {
        head   = 2'b00,
        body   = 2'b01,
        tail   = 2'b10,
        single = 2'b11   // head and tail in one flit
    } flit_kind_e;

    // 40 bits
    typedef struct packed {
        flit_kind_e           kind;
        logic [coord_w-1:0]   dst_x;
        logic [coord_w-1:0]   dst_y;
        logic [payload_w-1:0] payload;
    } flit_t;

    // one link direction: flit forward, credit backward
    typedef struct packed {
        logic  flit_wr;
        flit_t flit;
        logic  credit;   // one free slot returned per pulse
    } link_chan_t;

endpackage

`default_nettype wire

// ==== hw/input_port/input_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module input_fifo #(
    parameter int BUF_DEPTH = 4
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              wr_en,
    input  wire router_pkg::flit_t wr_flit,
    input  wire logic              rd_en,
    output router_pkg::flit_t      head_flit,
    output logic                   not_empty,
    output logic                   credit_out
);
    import router_pkg::*;

    localparam int ptr_w = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int cnt_w = $clog2(BUF_DEPTH + 1);

    flit_t            mem [BUF_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;   // flits held
    logic             pop;

    // wrap at BUF_DEPTH, depth need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        next_ptr = (ptr == ptr_w'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign pop       = rd_en && not_empty;
    assign head_flit = mem[rd_ptr];   // head visible one cycle after its write

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_flit;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_out <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_out <= pop;   // slot freed, tell upstream
        end
    end

    // upstream may only write while it holds a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_en && count == cnt_w'(BUF_DEPTH)))
        else $error("input_fifo: write into a full buffer, upstream credit violation");

endmodule

`default_nettype wire

// ==== hw/input_port/packet_route_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module packet_route_fsm #(
    parameter int ROUTER_X = 0,
    parameter int ROUTER_Y = 0
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire router_pkg::flit_t head_flit,
    input  wire logic              not_empty,
    input  wire logic              granted,
    output router_pkg::port_mask_t req
);
    import router_pkg::*;

    typedef enum logic {
        idle,
        in_packet   // head granted, waiting for the tail
    } state_e;

    state_e    state;
    port_idx_t xy_port;     // XY result for the current head
    port_idx_t held_port;   // output held for the rest of the packet
    port_idx_t req_port;

    // dimension order, x first then y
    always_comb begin
        if (int'(head_flit.dst_x) > ROUTER_X) begin
            xy_port = port_idx_t'(port_east);
        end else if (int'(head_flit.dst_x) < ROUTER_X) begin
            xy_port = port_idx_t'(port_west);
        end else if (int'(head_flit.dst_y) > ROUTER_Y) begin
            xy_port = port_idx_t'(port_north);
        end else if (int'(head_flit.dst_y) < ROUTER_Y) begin
            xy_port = port_idx_t'(port_south);
        end else begin
            xy_port = port_idx_t'(port_local);   // arrived
        end
    end

    assign req_port = (state == idle) ? xy_port : held_port;
    assign req      = not_empty ? (port_mask_t'(1) << req_port) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            held_port <= port_idx_t'(port_local);
        end else begin
            case (state)
                idle: begin
                    // a single flit needs no state, only a head opens a packet
                    if (granted && head_flit.kind == head) begin
                        state     <= in_packet;
                        held_port <= xy_port;
                    end
                end
                in_packet: begin
                    if (granted && head_flit.kind == tail) state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // upstream framing: between packets only a head or a single may wait
    a_packet_start: assert property (@(posedge clk) disable iff (!rst_n)
        (not_empty && state == idle) |-> (head_flit.kind inside {head, single}))
        else $error("packet_route_fsm: %s flit at buffer head outside a packet",
                    head_flit.kind.name());

endmodule

`default_nettype wire

// ==== hw/output_port/credit_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module credit_counter #(
    parameter int BUF_DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic credit_in,   // slot freed downstream
    input  wire logic consume,     // flit sent on this output
    output logic      credit_avail
);

    localparam int cnt_w = $clog2(BUF_DEPTH + 1);

    logic [cnt_w-1:0] count;   // free slots in the downstream buffer

    assign credit_avail = (count != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= cnt_w'(BUF_DEPTH);   // downstream starts empty
        end else begin
            case ({credit_in, consume})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // more credits back than flits sent means a broken downstream
    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        count <= cnt_w'(BUF_DEPTH))
        else $error("credit_counter: count %0d above depth %0d", count, BUF_DEPTH);

    // the allocator must not send without a credit
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        consume |-> (count != '0))
        else $error("credit_counter: flit sent with no downstream credit");

endmodule

`default_nettype wire

// ==== hw/switch_alloc.sv ====
`timescale 1ns/1ns
`default_nettype none

module switch_alloc (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire router_pkg::port_mask_t req [router_pkg::num_ports],
    input  wire router_pkg::flit_kind_e req_kind [router_pkg::num_ports],
    input  wire router_pkg::port_mask_t credit_avail,
    output router_pkg::port_mask_t      in_grant,
    output router_pkg::port_idx_t       out_sel [router_pkg::num_ports],
    output router_pkg::port_mask_t      out_valid
);
    import router_pkg::*;

    port_idx_t  rr_ptr [num_ports];       // first input to look at
    port_idx_t  lock_owner [num_ports];
    port_mask_t locked;                   // output held by a packet
    port_mask_t gnt [num_ports];          // gnt[out][in]

    // per output, first eligible input from the pointer onward
    always_comb begin
        int idx;
        for (int o = 0; o < num_ports; o++) begin
            gnt[o]       = '0;
            out_valid[o] = 1'b0;
            out_sel[o]   = '0;
            for (int k = 0; k < num_ports; k++) begin
                idx = (int'(rr_ptr[o]) + k) % num_ports;
                if (credit_avail[o] && !out_valid[o] && req[idx][o] &&
                    (!locked[o] || lock_owner[o] == port_idx_t'(idx))) begin
                    gnt[o][idx]  = 1'b1;
                    out_valid[o] = 1'b1;
                    out_sel[o]   = port_idx_t'(idx);
                end
            end
        end
    end

    always_comb begin
        in_grant = '0;
        for (int o = 0; o < num_ports; o++) begin
            in_grant = in_grant | gnt[o];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked <= '0;
            for (int o = 0; o < num_ports; o++) begin
                rr_ptr[o]     <= '0;
                lock_owner[o] <= '0;
            end
        end else begin
            for (int o = 0; o < num_ports; o++) begin
                if (out_valid[o]) begin
                    // winner goes to the back of the queue
                    rr_ptr[o] <= (out_sel[o] == port_idx_t'(num_ports - 1)) ?
                                 '0 : out_sel[o] + 1'b1;
                    if (req_kind[out_sel[o]] == head) begin
                        locked[o]     <= 1'b1;
                        lock_owner[o] <= out_sel[o];
                    end else if (req_kind[out_sel[o]] == tail) begin
                        locked[o] <= 1'b0;   // packet done
                    end
                end
            end
        end
    end

    // an input requests one output at a time, so two outputs never pick it
    for (genvar a = 0; a < num_ports; a++) begin : g_chk_a
        for (genvar b = a + 1; b < num_ports; b++) begin : g_chk_b
            a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
                (gnt[a] & gnt[b]) == '0)
                else $error("switch_alloc: outputs %0d and %0d granted the same input", a, b);
        end
    end

endmodule

`default_nettype wire

// ==== hw/crossbar.sv ====
`timescale 1ns/1ns
`default_nettype none

module crossbar (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire router_pkg::flit_t      in_flits [router_pkg::num_ports],
    input  wire router_pkg::port_idx_t  out_sel [router_pkg::num_ports],
    input  wire router_pkg::port_mask_t out_valid,
    output router_pkg::flit_t           out_flit [router_pkg::num_ports],
    output router_pkg::port_mask_t      out_wr
);
    import router_pkg::*;

    // second stage, the chosen head flit is captured at the grant edge
    always_ff @(posedge clk) begin
        for (int o = 0; o < num_ports; o++) begin
            if (out_valid[o]) begin
                out_flit[o] <= in_flits[out_sel[o]];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_wr <= '0;
        end else begin
            out_wr <= out_valid;   // link write strobe
        end
    end

endmodule

`default_nettype wire

// ==== hw/router_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module router_top #(
    parameter int BUF_DEPTH = 4,
    parameter int ROUTER_X  = 0,
    parameter int ROUTER_Y  = 0
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire router_pkg::link_chan_t chan_in [router_pkg::num_ports],
    output router_pkg::link_chan_t      chan_out [router_pkg::num_ports]
);
    import router_pkg::*;

    // input side, one per port
    wire flit_t      head_flit [num_ports];
    wire port_mask_t not_empty;
    wire port_mask_t fifo_credit;
    wire port_mask_t req [num_ports];
    wire flit_kind_e req_kind [num_ports];

    // output side
    wire port_mask_t credit_avail;
    wire port_mask_t in_grant;
    wire port_idx_t  out_sel [num_ports];
    wire port_mask_t out_valid;
    wire flit_t      out_flit [num_ports];
    wire port_mask_t out_wr;

    for (genvar p = 0; p < num_ports; p++) begin : g_port
        input_fifo #(
            .BUF_DEPTH(BUF_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_en     (chan_in[p].flit_wr),
            .wr_flit   (chan_in[p].flit),
            .rd_en     (in_grant[p]),
            .head_flit (head_flit[p]),
            .not_empty (not_empty[p]),
            .credit_out(fifo_credit[p])
        );

        packet_route_fsm #(
            .ROUTER_X(ROUTER_X),
            .ROUTER_Y(ROUTER_Y)
        ) u_route (
            .clk      (clk),
            .rst_n    (rst_n),
            .head_flit(head_flit[p]),
            .not_empty(not_empty[p]),
            .granted  (in_grant[p]),
            .req      (req[p])
        );

        // tracks the buffer of the neighbour behind output p
        credit_counter #(
            .BUF_DEPTH(BUF_DEPTH)
        ) u_credit (
            .clk         (clk),
            .rst_n       (rst_n),
            .credit_in   (chan_in[p].credit),
            .consume     (out_valid[p]),
            .credit_avail(credit_avail[p])
        );

        assign req_kind[p] = head_flit[p].kind;

        assign chan_out[p] = '{flit_wr: out_wr[p], flit: out_flit[p], credit: fifo_credit[p]};
    end

    switch_alloc u_alloc (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .req_kind    (req_kind),
        .credit_avail(credit_avail),
        .in_grant    (in_grant),
        .out_sel     (out_sel),
        .out_valid   (out_valid)
    );

    crossbar u_xbar (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_flits (head_flit),
        .out_sel  (out_sel),
        .out_valid(out_valid),
        .out_flit (out_flit),
        .out_wr   (out_wr)
    );

endmodule

`default_nettype wire

// ==== testbench/router_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module router_tb;
    import router_pkg::*;

    localparam int buf_depth = 4;
    localparam int router_x = 2;
    localparam int router_y = 2;
    localparam int rand_pkts = 12;   // per input
    localparam int max_len = 4;
    localparam int num_pkts = 25 + 10 + 2 + num_ports * rand_pkts;
    localparam int timeout_cycles = num_pkts * max_len * 40;
    // local, east, north, west, south as seen from (2,2)
    localparam int dst_x_list [5] = '{2, 4, 2, 0, 2};
    localparam int dst_y_list [5] = '{2, 1, 4, 3, 0};

    logic       clk = 1'b0;
    logic       rst_n = 1'b1;   // falls at time zero
    link_chan_t chan_in [num_ports];
    link_chan_t chan_out [num_ports];
    logic       tx_wr [num_ports] = '{default: 1'b0};
    flit_t      tx_flit [num_ports] = '{default: '0};
    logic       ret_credit [num_ports] = '{default: 1'b0};

    flit_t      tx_q [num_ports][$];               // waiting upstream
    flit_t      exp_q [num_ports * num_ports][$];  // src * num_ports + out
    int         up_avail [num_ports] = '{default: buf_depth};
    int         down_pend [num_ports] = '{default: 0};   // flits held downstream
    int         last_send_cyc [num_ports] = '{default: 0};
    int         open_src [num_ports] = '{default: 0};
    port_mask_t pkt_open = '0;
    port_mask_t hold = '0;   // downstream withholds credits
    port_mask_t out_wr_m;
    port_mask_t out_cr_m;
    int         cyc = 0;
    int         seq = 0;
    integer     seed = 32'h243b_8ac6;
    logic       started = 1'b0;
    logic       lat_check = 1'b0;
    logic       rand_gaps = 1'b0;

    router_top #(
        .BUF_DEPTH(buf_depth),
        .ROUTER_X (router_x),
        .ROUTER_Y (router_y)
    ) UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .chan_in (chan_in),
        .chan_out(chan_out)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            chan_in[p]  = '{flit_wr: tx_wr[p], flit: tx_flit[p], credit: ret_credit[p]};
            out_wr_m[p] = chan_out[p].flit_wr;
            out_cr_m[p] = chan_out[p].credit;
        end
    end

    task automatic stop_fail(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "testbench stopped at %0t", $time);
    endtask

    task automatic report_value(input string sig, input logic [63:0] exp, input logic [63:0] act);
        stop_fail($sformatf("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, sig, exp, act));
    endtask

    // XY order with x first
    function automatic int expected_port(input int dx, input int dy);
        if (dx > router_x) return port_east;
        if (dx < router_x) return port_west;
        if (dy > router_y) return port_north;
        if (dy < router_y) return port_south;
        return port_local;
    endfunction

    task automatic queue_packet(input int src, input int dx, input int dy, input int len);
        flit_t f;
        int    o;
        o = expected_port(dx, dy);
        for (int i = 0; i < len; i++) begin
            f.kind    = (len == 1) ? single : (i == 0) ? head : (i == len - 1) ? tail : body;
            f.dst_x   = coord_w'(dx);
            f.dst_y   = coord_w'(dy);
            f.payload = {3'(src), 29'(seq)};   // source tag plus unique number
            seq++;
            tx_q[src].push_back(f);
            exp_q[src * num_ports + o].push_back(f);
        end
    endtask

    task automatic wait_drain();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            @(negedge clk);
            busy = (pkt_open != '0);
            for (int p = 0; p < num_ports; p++) begin
                if (tx_q[p].size() != 0 || down_pend[p] != 0) busy = 1'b1;
            end
            for (int i = 0; i < num_ports * num_ports; i++) begin
                if (exp_q[i].size() != 0) busy = 1'b1;
            end
        end
        repeat (3) @(negedge clk);
        for (int p = 0; p < num_ports; p++) begin
            assert (up_avail[p] == buf_depth)
                else report_value($sformatf("upstream credits of input %0d", p),
                                  buf_depth, up_avail[p]);
        end
    endtask

    // upstream senders, scoreboard and downstream credit return
    always @(posedge clk) begin
        flit_t f;
        int    src;
        int    qi;
        if (!rst_n) begin
            for (int p = 0; p < num_ports; p++) begin
                tx_wr[p]      <= 1'b0;
                ret_credit[p] <= 1'b0;
            end
        end else begin
            for (int p = 0; p < num_ports; p++) begin
                if (chan_out[p].credit) up_avail[p]++;
                if (tx_q[p].size() > 0 && up_avail[p] > 0 &&
                    (!rand_gaps || ($random(seed) & 3) != 0)) begin
                    tx_flit[p] <= tx_q[p].pop_front();
                    tx_wr[p]   <= 1'b1;
                    up_avail[p]--;
                    last_send_cyc[p] = cyc;
                end else begin
                    tx_wr[p] <= 1'b0;
                end
            end
            for (int o = 0; o < num_ports; o++) begin
                if (chan_out[o].flit_wr) begin
                    f   = chan_out[o].flit;
                    src = int'(f.payload[31:29]);
                    qi  = src * num_ports + o;
                    assert (src < num_ports && exp_q[qi].size() > 0)
                        else stop_fail($sformatf("flit 0x%0h not expected on port %0d at %0t",
                                                 f, o, $time));
                    assert (f == exp_q[qi][0])
                        else report_value($sformatf("chan_out[%0d].flit", o), exp_q[qi][0], f);
                    void'(exp_q[qi].pop_front());
                    if (lat_check) begin
                        assert (cyc - last_send_cyc[src] - 1 == 2)
                            else report_value($sformatf("chan_out[%0d] latency", o), 2,
                                              cyc - last_send_cyc[src] - 1);
                    end
                    case (f.kind)
                        head: begin
                            assert (!pkt_open[o])
                                else report_value($sformatf("chan_out[%0d] open packet", o), 0, 1);
                            pkt_open[o] = 1'b1;
                            open_src[o] = src;
                        end
                        single: assert (!pkt_open[o])
                            else report_value($sformatf("chan_out[%0d] open packet", o), 0, 1);
                        default: begin
                            assert (pkt_open[o] && open_src[o] == src)
                                else report_value($sformatf("chan_out[%0d] packet source", o),
                                                  open_src[o], src);
                            if (f.kind == tail) pkt_open[o] = 1'b0;
                        end
                    endcase
                    down_pend[o]++;
                end
                if (down_pend[o] > 0 && !hold[o] && ($random(seed) & 1)) begin
                    ret_credit[o] <= 1'b1;
                    down_pend[o]--;
                end else begin
                    ret_credit[o] <= 1'b0;
                end
                cyc = (o == num_ports - 1) ? cyc + 1 : cyc;
            end
        end
    end

    a_idle_before_start: assert property (@(posedge clk)
        !started |-> (out_wr_m == '0 && out_cr_m == '0))
        else report_value("chan_out flit_wr and credit", 0, {out_wr_m, out_cr_m});

    for (genvar g = 0; g < num_ports; g++) begin : g_credit_chk
        a_up_credit_range: assert property (@(posedge clk) disable iff (!rst_n)
            up_avail[g] >= 0 && up_avail[g] <= buf_depth)
            else report_value($sformatf("upstream credits of input %0d", g), buf_depth,
                              $sampled(up_avail[g]));
        a_down_fill: assert property (@(posedge clk) disable iff (!rst_n)
            down_pend[g] <= buf_depth)
            else report_value($sformatf("downstream fill behind output %0d", g), buf_depth,
                              $sampled(down_pend[g]));
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        stop_fail("watchdog expired before the traffic drained");
    end

    initial begin
        rst_n <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(negedge clk);
        started = 1'b1;
        lat_check = 1'b1;   // idle router and one single at a time
        for (int p = 0; p < num_ports; p++) begin
            for (int d = 0; d < 5; d++) begin
                queue_packet(p, dst_x_list[d], dst_y_list[d], 1);
                wait_drain();
            end
        end
        lat_check = 1'b0;
        for (int p = 0; p < num_ports; p++) queue_packet(p, 2, 2, 3);
        for (int p = 0; p < num_ports; p++) queue_packet(p, 4, 2, max_len);
        wait_drain();
        hold[port_north] = 1'b1;
        queue_packet(port_local, 2, 3, max_len);
        queue_packet(port_local, 2, 3, max_len);
        repeat (40) @(negedge clk);
        assert (down_pend[port_north] == buf_depth)
            else report_value("flits out of chan_out[north] while held", buf_depth,
                              down_pend[port_north]);
        hold[port_north] = 1'b0;
        wait_drain();
        rand_gaps = 1'b1;
        for (int n = 0; n < rand_pkts; n++) begin
            for (int p = 0; p < num_ports; p++) begin
                queue_packet(p, ($random(seed) & 32'h7fff_ffff) % 5,
                             ($random(seed) & 32'h7fff_ffff) % 5, 1 + ($random(seed) & 3));
            end
        end
        wait_drain();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
common/router_pkg.sv
hw/input_port/input_fifo.sv
hw/input_port/packet_route_fsm.sv
hw/output_port/credit_counter.sv
hw/switch_alloc.sv
hw/crossbar.sv
hw/router_top.sv
testbench/router_tb.sv
